/* common/udma_cfg_pkg.sv */
/*
 * Channel register map and configuration types. Offsets are word aligned and
 * decoded from PADDR[6:2] only; local addresses are 12 bits wide.
 */
package udma_cfg_pkg;

    ////////////////////////////////////////
    // Register map
    ////////////////////////////////////////

    typedef enum logic [4:0] {
        REG_RX_SADDR = 5'h00,  // 0x00 RX start address
        REG_RX_SIZE  = 5'h01,  // 0x04 RX size, reads bytes left
        REG_RX_CFG   = 5'h02,  // 0x08 RX kick
        REG_TX_SADDR = 5'h03,  // 0x0C TX start address
        REG_TX_SIZE  = 5'h04,  // 0x10 TX size, reads bytes left
        REG_TX_CFG   = 5'h05,  // 0x14 TX kick
        REG_STATUS   = 5'h09   // 0x24 Busy flags
    } reg_addr_e;

    typedef logic [31:0] apb_data_t;
    typedef logic [11:0] l2_addr_t;    // Byte address into local memory
    typedef logic [15:0] xfer_size_t;  // Transfer length in bytes

    localparam int unsigned cfg_enable_bit     = 4;  // Kick value 0x14 sets this
    localparam int unsigned status_tx_busy_bit = 0;
    localparam int unsigned status_rx_busy_bit = 1;

    // One per direction, start is a single-cycle pulse
    typedef struct packed {
        logic       start;
        l2_addr_t   saddr;
        xfer_size_t size;
    } xfer_cmd_t;

endpackage

/* common/udma_stream_pkg.sv */
/*
 * Stream types shared by both engines, the memory and the top level.
 * A beat carries one little-endian word and its count of valid bytes.
 */
package udma_stream_pkg;

    typedef logic [31:0] word_t;
    typedef logic [2:0]  byte_cnt_t;  // 1 to 4 valid bytes

    localparam byte_cnt_t beat_bytes = 3'd4;  // Full word

    ////////////////////////////////////////
    // Stream beat
    ////////////////////////////////////////

    typedef struct packed {
        word_t     data;    // Byte 0 in bits 7:0
        byte_cnt_t nbytes;
    } stream_beat_t;

    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } engine_state_e;

endpackage

/* regs/udma_reg_decode.sv */
/*
 * APB slave with zero wait states. Unmapped offsets raise PSLVERR, read 0 and
 * ignore writes. A CFG kick is dropped unless the size is nonzero and idle.
 */
`timescale 1ns/1ps

module udma_reg_decode
    import udma_cfg_pkg::*;
(
    input  logic        sys_clk,
    input  logic        rst_n,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [31:0] paddr_i,
    input  apb_data_t   pwdata_i,
    input  xfer_size_t  tx_left_i,
    input  xfer_size_t  rx_left_i,
    input  logic        tx_busy_i,
    input  logic        rx_busy_i,
    output apb_data_t   prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    output xfer_cmd_t   tx_cmd_o,
    output xfer_cmd_t   rx_cmd_o
);

    reg_addr_e reg_addr;
    logic      access;
    logic      wr_access;
    logic      mapped;
    logic      tx_kick;
    logic      rx_kick;
    apb_data_t rdata;
    xfer_cmd_t tx_cmd_q;
    xfer_cmd_t rx_cmd_q;

    assign reg_addr  = reg_addr_e'(paddr_i[6:2]);
    assign access    = psel_i & penable_i;  // Access phase
    assign wr_access = access & pwrite_i;

    ////////////////////////////////////////
    // Read path
    ////////////////////////////////////////

    always_comb begin
        mapped = 1'b1;
        rdata  = '0;
        case (reg_addr)
            REG_RX_SADDR: rdata = apb_data_t'(rx_cmd_q.saddr);
            REG_RX_SIZE:  rdata = apb_data_t'(rx_left_i);  // Bytes left
            REG_RX_CFG:   rdata[cfg_enable_bit] = rx_busy_i;
            REG_TX_SADDR: rdata = apb_data_t'(tx_cmd_q.saddr);
            REG_TX_SIZE:  rdata = apb_data_t'(tx_left_i);
            REG_TX_CFG:   rdata[cfg_enable_bit] = tx_busy_i;
            REG_STATUS: begin
                rdata[status_tx_busy_bit] = tx_busy_i;
                rdata[status_rx_busy_bit] = rx_busy_i;
            end
            default:      mapped = 1'b0;
        endcase
    end

    assign prdata_o  = rdata;
    assign pready_o  = 1'b1;                // Never stalls
    assign pslverr_o = access & ~mapped;

    // A pending start also counts as busy
    assign tx_kick = wr_access & (reg_addr == REG_TX_CFG) & pwdata_i[cfg_enable_bit]
                   & (tx_cmd_q.size != '0) & ~tx_busy_i & ~tx_cmd_q.start;
    assign rx_kick = wr_access & (reg_addr == REG_RX_CFG) & pwdata_i[cfg_enable_bit]
                   & (rx_cmd_q.size != '0) & ~rx_busy_i & ~rx_cmd_q.start;

    ////////////////////////////////////////
    // Configuration registers
    ////////////////////////////////////////

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_cmd_q <= '0;
            rx_cmd_q <= '0;
        end else begin
            tx_cmd_q.start <= tx_kick;  // Start one cycle after access
            rx_cmd_q.start <= rx_kick;
            if (wr_access) begin
                case (reg_addr)
                    REG_RX_SADDR: rx_cmd_q.saddr <= l2_addr_t'(pwdata_i);
                    REG_RX_SIZE:  rx_cmd_q.size  <= xfer_size_t'(pwdata_i);
                    REG_TX_SADDR: tx_cmd_q.saddr <= l2_addr_t'(pwdata_i);
                    REG_TX_SIZE:  tx_cmd_q.size  <= xfer_size_t'(pwdata_i);
                    default: ;
                endcase
            end
        end
    end

    assign tx_cmd_o = tx_cmd_q;
    assign rx_cmd_o = rx_cmd_q;

endmodule

/* dma/udma_tx_engine.sv */
/*
 * TX engine. Streams words from local memory starting at the programmed
 * address; the last beat carries only the remaining bytes.
 */
`timescale 1ns/1ps

module udma_tx_engine
    import udma_cfg_pkg::*;
    import udma_stream_pkg::*;
(
    input  logic         sys_clk,
    input  logic         rst_n,
    input  xfer_cmd_t    cmd_i,
    input  word_t        rd_data_i,
    input  logic         tx_ready_i,
    output l2_addr_t     rd_addr_o,
    output stream_beat_t tx_beat_o,
    output logic         tx_valid_o,
    output xfer_size_t   left_o,
    output logic         busy_o,
    output logic         eot_o
);

    engine_state_e state_q;
    l2_addr_t      addr_q;
    xfer_size_t    left_q;
    logic          eot_q;
    byte_cnt_t     nbytes;
    logic          fire;
    logic          last;

    assign last   = (left_q <= xfer_size_t'(beat_bytes));
    assign nbytes = last ? byte_cnt_t'(left_q) : beat_bytes;
    assign fire   = tx_valid_o & tx_ready_i;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            addr_q  <= '0;
            left_q  <= '0;
            eot_q   <= 1'b0;
        end else begin
            eot_q <= 1'b0;
            case (state_q)
                IDLE: if (cmd_i.start) begin
                    addr_q  <= cmd_i.saddr;
                    left_q  <= cmd_i.size;
                    state_q <= RUN;
                end
                RUN: if (fire) begin
                    addr_q <= addr_q + l2_addr_t'(beat_bytes);  // Wraps in memory
                    left_q <= left_q - xfer_size_t'(nbytes);
                    if (last) begin
                        state_q <= IDLE;
                        eot_q   <= 1'b1;  // Pulse after last handshake
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Address and count hold while stalled, so the beat holds too
    assign rd_addr_o  = addr_q;
    assign tx_valid_o = (state_q == RUN);
    assign tx_beat_o  = '{data: rd_data_i, nbytes: nbytes};
    assign left_o     = left_q;
    assign busy_o     = (state_q == RUN);
    assign eot_o      = eot_q;

endmodule

/* dma/udma_rx_engine.sv */
/*
 * RX engine. Accepts one beat per cycle while running and writes it to local
 * memory. The sender's byte count is ignored; strobes follow the bytes left.
 */
`timescale 1ns/1ps

module udma_rx_engine
    import udma_cfg_pkg::*;
    import udma_stream_pkg::*;
(
    input  logic         sys_clk,
    input  logic         rst_n,
    input  xfer_cmd_t    cmd_i,
    input  stream_beat_t rx_beat_i,
    input  logic         rx_valid_i,
    output logic         rx_ready_o,
    output logic         wr_en_o,
    output l2_addr_t     wr_addr_o,
    output logic [3:0]   wr_strb_o,
    output word_t        wr_data_o,
    output xfer_size_t   left_o,
    output logic         busy_o,
    output logic         eot_o
);

    engine_state_e state_q;
    l2_addr_t      addr_q;
    xfer_size_t    left_q;
    logic          eot_q;
    byte_cnt_t     nbytes;
    logic          fire;
    logic          last;

    assign last   = (left_q <= xfer_size_t'(beat_bytes));
    assign nbytes = last ? byte_cnt_t'(left_q) : beat_bytes;
    assign fire   = rx_valid_i & rx_ready_o;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            addr_q  <= '0;
            left_q  <= '0;
            eot_q   <= 1'b0;
        end else begin
            eot_q <= 1'b0;
            if (state_q == IDLE && cmd_i.start) begin
                addr_q  <= cmd_i.saddr;
                left_q  <= cmd_i.size;
                state_q <= RUN;
            end else if (fire) begin
                addr_q  <= addr_q + l2_addr_t'(beat_bytes);
                left_q  <= left_q - xfer_size_t'(nbytes);
                state_q <= last ? IDLE : RUN;
                eot_q   <= last;
            end
        end
    end

    // Partial last word only touches the bytes left
    always_comb begin
        case (nbytes)
            3'd1:    wr_strb_o = 4'b0001;
            3'd2:    wr_strb_o = 4'b0011;
            3'd3:    wr_strb_o = 4'b0111;
            default: wr_strb_o = 4'b1111;
        endcase
    end

    assign rx_ready_o = (state_q == RUN);
    assign wr_en_o    = fire;
    assign wr_addr_o  = addr_q;
    assign wr_data_o  = rx_beat_i.data;
    assign left_o     = left_q;
    assign busy_o     = (state_q == RUN);
    assign eot_o      = eot_q;

endmodule

/* source/l2_byte_mem.sv */
/*
 * Local byte memory. MemBytes is a power of two up to 4096. Contents are not
 * reset and are undefined until written.
 */
`timescale 1ns/1ps

module l2_byte_mem
    import udma_cfg_pkg::*;
    import udma_stream_pkg::*;
#(
    parameter int unsigned MemBytes = 4096
) (
    input  logic       sys_clk,
    input  l2_addr_t   rd_addr_i,
    input  logic       wr_en_i,
    input  l2_addr_t   wr_addr_i,
    input  logic [3:0] wr_strb_i,
    input  word_t      wr_data_i,
    output word_t      rd_data_o
);

    logic [7:0] mem_q [MemBytes];

    // Little-endian word read, addresses wrap at MemBytes
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rd_data_o[8*i +: 8] = mem_q[(int'(rd_addr_i) + i) % MemBytes];
        end
    end

    always_ff @(posedge sys_clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wr_en_i && wr_strb_i[i]) begin
                mem_q[(int'(wr_addr_i) + i) % MemBytes] <= wr_data_i[8*i +: 8];
            end
        end
    end

endmodule

/* source/udma_channel_top.sv */
/*
 * uDMA channel: APB registers, TX and RX stream engines, local byte memory.
 * MemBytes is a power of two no larger than 4096.
 */
`timescale 1ns/1ps

module udma_channel_top
    import udma_cfg_pkg::*;
    import udma_stream_pkg::*;
#(
    parameter int unsigned MemBytes = 4096
) (
    input  logic         sys_clk,
    input  logic         rst_n,
    input  logic         psel_i,
    input  logic         penable_i,
    input  logic         pwrite_i,
    input  logic [31:0]  paddr_i,
    input  apb_data_t    pwdata_i,
    output apb_data_t    prdata_o,
    output logic         pready_o,
    output logic         pslverr_o,
    input  stream_beat_t rx_beat_i,
    input  logic         rx_valid_i,
    output logic         rx_ready_o,
    output stream_beat_t tx_beat_o,
    output logic         tx_valid_o,
    input  logic         tx_ready_i,
    output logic         tx_eot_o,
    output logic         rx_eot_o
);

    xfer_cmd_t  tx_cmd, rx_cmd;
    xfer_size_t tx_left, rx_left;
    logic       tx_busy, rx_busy;
    l2_addr_t   rd_addr, wr_addr;
    word_t      rd_data, wr_data;
    logic       wr_en;
    logic [3:0] wr_strb;

    udma_reg_decode regs_i (
        .sys_clk, .rst_n, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o,
        .tx_left_i(tx_left), .rx_left_i(rx_left), .tx_busy_i(tx_busy), .rx_busy_i(rx_busy),
        .tx_cmd_o(tx_cmd), .rx_cmd_o(rx_cmd)
    );

    udma_tx_engine tx_i (
        .sys_clk, .rst_n, .cmd_i(tx_cmd), .rd_data_i(rd_data), .tx_ready_i,
        .rd_addr_o(rd_addr), .tx_beat_o, .tx_valid_o,
        .left_o(tx_left), .busy_o(tx_busy), .eot_o(tx_eot_o)
    );

    udma_rx_engine rx_i (
        .sys_clk, .rst_n, .cmd_i(rx_cmd), .rx_beat_i, .rx_valid_i, .rx_ready_o,
        .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_strb_o(wr_strb), .wr_data_o(wr_data),
        .left_o(rx_left), .busy_o(rx_busy), .eot_o(rx_eot_o)
    );

    l2_byte_mem #(.MemBytes(MemBytes)) mem_i (
        .sys_clk, .rd_addr_i(rd_addr), .wr_en_i(wr_en), .wr_addr_i(wr_addr),
        .wr_strb_i(wr_strb), .wr_data_i(wr_data), .rd_data_o(rd_data)
    );

endmodule

/* tb/udma_channel_chk.sv */
/*
 * Stream and APB checks, bound into udma_channel_top. Reaches the internal
 * command and busy nets of the top level by name.
 */
`timescale 1ns/1ps

module udma_channel_chk
    import udma_cfg_pkg::*;
    import udma_stream_pkg::*;
(
    input logic         sys_clk,
    input logic         rst_n,
    input logic         pready_i,
    input logic         tx_valid_i,
    input logic         tx_ready_i,
    input stream_beat_t tx_beat_i,
    input xfer_cmd_t    tx_cmd_i,
    input xfer_cmd_t    rx_cmd_i,
    input logic         tx_busy_i,
    input logic         rx_busy_i
);

    int unsigned fail_cnt = 0;  // Read by the testbench

    ////////////////////////////////////////
    // Stream and APB rules
    ////////////////////////////////////////

    tx_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
        tx_valid_i && !tx_ready_i |=> tx_valid_i && $stable(tx_beat_i))
        else begin
            $error("TX beat or valid changed while stalled");
            fail_cnt++;
        end

    apb_ready: assert property (@(posedge sys_clk) disable iff (!rst_n) pready_i)
        else begin
            $error("APB pready dropped");
            fail_cnt++;
        end

    tx_start_idle: assert property (@(posedge sys_clk) disable iff (!rst_n)
        tx_cmd_i.start |-> !tx_busy_i)
        else begin
            $error("TX start while TX busy");
            fail_cnt++;
        end

    rx_start_idle: assert property (@(posedge sys_clk) disable iff (!rst_n)
        rx_cmd_i.start |-> !rx_busy_i)
        else begin
            $error("RX start while RX busy");
            fail_cnt++;
        end

endmodule

bind udma_channel_top udma_channel_chk chk_i (
    .sys_clk(sys_clk), .rst_n(rst_n), .pready_i(pready_o),
    .tx_valid_i(tx_valid_o), .tx_ready_i(tx_ready_i), .tx_beat_i(tx_beat_o),
    .tx_cmd_i(tx_cmd), .rx_cmd_i(rx_cmd), .tx_busy_i(tx_busy), .rx_busy_i(rx_busy)
);

/* tb/tb_udma_channel.sv */
/*
 * Testbench for the uDMA channel. One RX transfer fills memory, then two TX
 * transfers read it back, the second one under random back-pressure.
 */
`timescale 1ns/1ps

module tb_udma_channel
    import udma_cfg_pkg::*;
    import udma_stream_pkg::*;
();

    localparam int unsigned MemBytes  = 4096;
    localparam int unsigned MaxCycles = 4000;  // 3 transfers of 16 beats plus APB

    logic         sys_clk;
    logic         rst_n;
    logic         psel;
    logic         penable;
    logic         pwrite;
    logic [31:0]  paddr;
    apb_data_t    pwdata;
    apb_data_t    prdata;
    logic         pready;
    logic         pslverr;
    stream_beat_t rx_beat;
    logic         rx_valid;
    logic         rx_ready;
    stream_beat_t tx_beat;
    logic         tx_valid;
    logic         tx_ready;
    logic         tx_eot;
    logic         rx_eot;

    integer     seed = 32'h609d_43bd;
    int         cycles = 0;
    int         tx_eot_cnt = 0;
    int         rx_eot_cnt = 0;
    logic [7:0] ref_mem [MemBytes];  // Bytes sent on RX

    udma_channel_top #(.MemBytes(MemBytes)) dut_i (
        .sys_clk(sys_clk), .rst_n(rst_n),
        .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
        .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
        .rx_beat_i(rx_beat), .rx_valid_i(rx_valid), .rx_ready_o(rx_ready),
        .tx_beat_o(tx_beat), .tx_valid_o(tx_valid), .tx_ready_i(tx_ready),
        .tx_eot_o(tx_eot), .rx_eot_o(rx_eot)
    );

    initial begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    ////////////////////////////////////////
    // Monitors
    ////////////////////////////////////////

    always @(posedge sys_clk) begin
        cycles++;
        if (cycles >= MaxCycles) begin
            $display("Timeout: run did not finish within %0d cycles", MaxCycles);
            fail_run();
        end
    end

    // Mid-cycle, so the registered pulses are stable
    always @(negedge sys_clk) begin
        if (tx_eot) tx_eot_cnt++;
        if (rx_eot) rx_eot_cnt++;
        if (dut_i.chk_i.fail_cnt != 0) begin
            $display("A bound stream or APB assertion failed");
            fail_run();
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic l2_addr_t byte_index(input l2_addr_t base, input int offset);
        return base + l2_addr_t'(offset);  // Wraps like the memory
    endfunction

    function automatic logic [31:0] reg_offset(input reg_addr_e r);
        return {25'd0, r, 2'b00};
    endfunction

    task automatic apb_access(input logic write, input logic [31:0] addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        @(posedge sys_clk);
        #1;
        psel    = 1'b1;  // Setup phase
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge sys_clk);
        #1;
        penable = 1'b1;  // Access phase
        #4;
        rdata = prdata;
        err   = pslverr;
        @(posedge sys_clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input reg_addr_e r, input apb_data_t data);
        apb_data_t rdata;
        logic      err;
        apb_access(1'b1, reg_offset(r), data, rdata, err);
        check_eq("pslverr_o", 32'(err), 32'h0);
    endtask

    task automatic read_reg(input reg_addr_e r, output apb_data_t data);
        logic err;
        apb_access(1'b0, reg_offset(r), '0, data, err);
        check_eq("pslverr_o", 32'(err), 32'h0);
    endtask

    // Sends ceil(size/4) beats with random gaps, records the bytes kept
    task automatic feed_rx(input l2_addr_t addr, input int size);
        int    left;
        int    beat;
        int    n;
        int    i;
        logic  accepted;
        word_t data;
        left = size;
        beat = 0;
        while (left > 0) begin
            while (rand_below(2) == 1) begin
                rx_valid = 1'b0;
                @(posedge sys_clk);
                #1;
            end
            data           = word_t'($random(seed));
            rx_valid       = 1'b1;
            rx_beat.data   = data;
            rx_beat.nbytes = byte_cnt_t'(rand_below(5));  // Ignored by RX
            accepted       = 1'b0;
            while (!accepted) begin
                #4;
                accepted = rx_ready;
                @(posedge sys_clk);
                #1;
            end
            n = (left < 4) ? left : 4;
            for (i = 0; i < n; i++) begin
                ref_mem[byte_index(addr, 4 * beat + i)] = data[8*i +: 8];
            end
            left -= n;
            beat++;
        end
        rx_valid = 1'b0;
    endtask

    task automatic collect_tx(input l2_addr_t addr, input int size, input logic random_ready);
        int left;
        int beats;
        int exp_n;
        int i;
        left  = size;
        beats = 0;
        while (left > 0) begin
            tx_ready = random_ready ? (rand_below(2) == 1) : 1'b1;
            #4;
            if (tx_valid && tx_ready) begin
                exp_n = (left < 4) ? left : 4;
                check_eq("tx_beat_o.nbytes", 32'(tx_beat.nbytes), 32'(exp_n));
                for (i = 0; i < exp_n; i++) begin
                    check_eq("tx_beat_o.data byte", 32'(tx_beat.data[8*i +: 8]),
                             32'(ref_mem[byte_index(addr, 4 * beats + i)]));
                end
                left -= exp_n;
                beats++;
            end
            @(posedge sys_clk);
            #1;
        end
        tx_ready = 1'b0;
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        apb_data_t rdata;
        logic      err;
        l2_addr_t  addr;
        int        size;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        rx_beat  = '0;
        rx_valid = 1'b0;
        tx_ready = 1'b0;
        rst_n    = 1'b0;
        repeat (16) @(posedge sys_clk);
        #1;
        rst_n = 1'b1;

        check_eq("tx_valid_o", 32'(tx_valid), 32'h0);
        check_eq("rx_ready_o", 32'(rx_ready), 32'h0);
        check_eq("tx_eot_o", 32'(tx_eot), 32'h0);
        check_eq("rx_eot_o", 32'(rx_eot), 32'h0);
        read_reg(REG_STATUS, rdata);
        check_eq("prdata_o", rdata, 32'h0);

        addr = l2_addr_t'(rand_below(MemBytes / 4) * 4);
        size = 1 + int'(rand_below(64));
        write_reg(REG_TX_SADDR, 32'(~addr & 12'hffc));
        write_reg(REG_RX_SADDR, 32'(addr));
        read_reg(REG_TX_SADDR, rdata);
        check_eq("prdata_o", rdata, 32'(~addr & 12'hffc));
        read_reg(REG_RX_SADDR, rdata);
        check_eq("prdata_o", rdata, 32'(addr));
        apb_access(1'b0, 32'h30, '0, rdata, err);  // Unmapped read
        check_eq("pslverr_o", 32'(err), 32'h1);
        check_eq("prdata_o", rdata, 32'h0);
        apb_access(1'b1, 32'h30, 32'hffff_ffff, rdata, err);
        check_eq("pslverr_o", 32'(err), 32'h1);

        // RX fills memory while a second kick lands on a busy engine
        write_reg(REG_RX_SIZE, 32'(size));
        write_reg(REG_RX_CFG, 32'h14);
        write_reg(REG_RX_CFG, 32'h14);
        feed_rx(addr, size);
        wait (rx_eot_cnt == 1);
        repeat (4) @(posedge sys_clk);
        #1;
        check_eq("rx_eot_o pulses", 32'(rx_eot_cnt), 32'h1);
        check_eq("rx_ready_o", 32'(rx_ready), 32'h0);
        read_reg(REG_RX_SIZE, rdata);
        check_eq("prdata_o", rdata, 32'h0);

        // TX readback, always ready
        write_reg(REG_TX_SADDR, 32'(addr));
        write_reg(REG_TX_SIZE, 32'(size));
        write_reg(REG_TX_CFG, 32'h14);
        collect_tx(addr, size, 1'b0);
        wait (tx_eot_cnt == 1);
        repeat (4) @(posedge sys_clk);
        #1;
        check_eq("tx_eot_o pulses", 32'(tx_eot_cnt), 32'h1);
        check_eq("tx_valid_o", 32'(tx_valid), 32'h0);
        read_reg(REG_TX_SIZE, rdata);
        check_eq("prdata_o", rdata, 32'h0);

        // TX again, stalled at first, second kick lands while busy
        write_reg(REG_TX_CFG, 32'h14);
        write_reg(REG_TX_CFG, 32'h14);
        read_reg(REG_STATUS, rdata);
        check_eq("prdata_o", rdata, 32'h1);
        collect_tx(addr, size, 1'b1);
        wait (tx_eot_cnt == 2);
        repeat (8) @(posedge sys_clk);
        #1;
        check_eq("tx_eot_o pulses", 32'(tx_eot_cnt), 32'h2);
        read_reg(REG_STATUS, rdata);
        check_eq("prdata_o", rdata, 32'h0);

        if (dut_i.chk_i.fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* build.f */
common/udma_cfg_pkg.sv
common/udma_stream_pkg.sv
regs/udma_reg_decode.sv
dma/udma_tx_engine.sv
dma/udma_rx_engine.sv
source/l2_byte_mem.sv
source/udma_channel_top.sv
tb/udma_channel_chk.sv
tb/tb_udma_channel.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the uDMA channel testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 -f build.f --top-module tb_udma_channel; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/Vtb_udma_channel 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -Fqx "Simulation completed successfully"; then
    exit 0
fi
echo "Pass message not found in simulator output"
exit 1
